/* core_bus_config.svh */
`ifndef CORE_BUS_CONFIG_SVH
`define CORE_BUS_CONFIG_SVH

// ram depth in words, low address bits index it
`define CORE_RAM_WORDS 1024

// random transactions per port
`define CORE_TEST_OPS 400

`endif

/* core_bus_pkg.sv */
`default_nettype none

package core_bus_pkg;

	typedef logic [31:0] word;
	typedef logic [29:0] ptr; // word address, byte address is {ptr, 2'b00}
	typedef logic [3:0] be_t;

	typedef struct packed {
		ptr addr;
		logic write;
		logic ex_lock; // load-locked / store-conditional
		word data_wr;
		be_t be;
	} core_req_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		ptr adr;
		word dat;
		be_t sel;
	} wb_m2s_t;

	typedef struct packed {
		logic ack;
		word dat;
	} wb_s2m_t;

	typedef enum logic {
		INSN,
		DATA
	} arb_master_e;

	typedef enum logic [1:0] {
		IDLE,
		WB_CYCLE,
		EX_REJECT
	} bridge_state_e;

endpackage

`default_nettype wire

/* core_mmu_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module core_mmu_arbiter (
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    insn_start,
	input  core_bus_pkg::ptr        insn_addr,
	input  logic                    data_start,
	input  core_bus_pkg::core_req_t data_req,

	input  logic                    bus_ready,
	input  logic                    bus_ex_fail,
	input  core_bus_pkg::word       bus_data_rd,

	output logic                    bus_start,
	output core_bus_pkg::core_req_t bus_req,

	output logic                    insn_ready,
	output logic                    data_ready,
	output logic                    data_ex_fail,
	output core_bus_pkg::word       insn_data_rd,
	output core_bus_pkg::word       data_data_rd
);

	core_bus_pkg::arb_master_e master;
	core_bus_pkg::arb_master_e next_master;
	core_bus_pkg::core_req_t insn_req;
	core_bus_pkg::core_req_t hold_req;
	logic active;
	logic hold_start;
	logic hold_issue;
	logic hold_free;
	logic transition;

	// fetches are plain full-word reads
	always_comb begin
		insn_req = '0;
		insn_req.addr = insn_addr;
		insn_req.be = '1;
	end

	// ownership only moves when the bus is idle or finishing
	always_comb begin
		next_master = master;
		if (bus_ready || !active) begin
			if (master == core_bus_pkg::DATA)
				next_master = data_start ? core_bus_pkg::DATA : core_bus_pkg::INSN;
			else if (data_start || hold_start)
				next_master = core_bus_pkg::DATA; // data wins a tie
		end
	end

	assign transition = master != next_master;
	assign hold_issue = transition && hold_start; // held request belongs to the new owner
	assign hold_free = transition || !hold_start;

	always_comb begin
		if (next_master == core_bus_pkg::DATA) begin
			bus_req = data_req;
			bus_start = data_start;
		end else begin
			bus_req = insn_req;
			bus_start = insn_start;
		end

		if (hold_issue) begin
			bus_req = hold_req;
			bus_start = 1'b1;
		end
	end

	assign insn_ready = bus_ready && master == core_bus_pkg::INSN;
	assign data_ready = bus_ready && master == core_bus_pkg::DATA;
	assign data_ex_fail = data_ready && bus_ex_fail;

	// one shared read path
	assign insn_data_rd = bus_data_rd;
	assign data_data_rd = bus_data_rd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			master <= core_bus_pkg::INSN;
			active <= 1'b0;
			hold_start <= 1'b0;
		end else begin
			master <= next_master;
			active <= bus_start || (active && !bus_ready);

			// capture whichever side is not steered onto the bus
			if (hold_free)
				hold_start <= (next_master == core_bus_pkg::DATA) ? insn_start : data_start;
		end
	end

	always_ff @(posedge clk) begin
		if (hold_free)
			hold_req <= (next_master == core_bus_pkg::DATA) ? insn_req : data_req;
	end

endmodule

`default_nettype wire

/* core_wb_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module core_wb_bridge (
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    bus_start,
	input  core_bus_pkg::core_req_t bus_req,
	output logic                    bus_ready,
	output logic                    bus_ex_fail,
	output core_bus_pkg::word       bus_data_rd,

	output core_bus_pkg::wb_m2s_t   wb_out,
	input  core_bus_pkg::wb_s2m_t   wb_in
);

	core_bus_pkg::bridge_state_e state;
	core_bus_pkg::bridge_state_e next_state;
	core_bus_pkg::core_req_t req_q;
	core_bus_pkg::ptr res_addr;
	logic res_valid;
	logic accept;
	logic ex_write;
	logic ex_match;

	assign ex_write = bus_req.write && bus_req.ex_lock;
	assign ex_match = res_valid && res_addr == bus_req.addr;

	always_comb begin
		bus_ready = 1'b0;
		bus_ex_fail = 1'b0;
		case (state)
			core_bus_pkg::WB_CYCLE: bus_ready = wb_in.ack;
			core_bus_pkg::EX_REJECT: begin
				bus_ready = 1'b1;
				bus_ex_fail = 1'b1;
			end
			default: begin
				bus_ready = 1'b0;
			end
		endcase
	end

	assign bus_data_rd = wb_in.dat;

	// back-to-back start allowed in the ready cycle
	assign accept = bus_start && (state == core_bus_pkg::IDLE || bus_ready);

	always_comb begin
		next_state = state;
		if (accept)
			next_state = (ex_write && !ex_match) ? core_bus_pkg::EX_REJECT
				: core_bus_pkg::WB_CYCLE;
		else if (bus_ready)
			next_state = core_bus_pkg::IDLE;
	end

	always_comb begin
		wb_out.cyc = state == core_bus_pkg::WB_CYCLE;
		wb_out.stb = state == core_bus_pkg::WB_CYCLE;
		wb_out.we = req_q.write;
		wb_out.adr = req_q.addr;
		wb_out.dat = req_q.data_wr;
		wb_out.sel = req_q.be;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= core_bus_pkg::IDLE;
			res_valid <= 1'b0;
		end else begin
			state <= next_state;
			if (accept) begin
				if (bus_req.write)
					res_valid <= 1'b0; // any store drops the reservation
				else if (bus_req.ex_lock)
					res_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= bus_req;
			if (!bus_req.write && bus_req.ex_lock)
				res_addr <= bus_req.addr;
		end
	end

endmodule

`default_nettype wire

/* core_wb_ram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_bus_config.svh"

module core_wb_ram (
	input  logic                  clk,
	input  logic                  rst_n,
	input  core_bus_pkg::wb_m2s_t wb_in,
	output core_bus_pkg::wb_s2m_t wb_out
);

	localparam int ADDR_W = $clog2(`CORE_RAM_WORDS);
	localparam int LANES = $bits(core_bus_pkg::be_t);

	core_bus_pkg::word mem [`CORE_RAM_WORDS];
	core_bus_pkg::word rd_q;
	logic [ADDR_W-1:0] idx;
	logic ack_q;
	logic access;

	assign idx = wb_in.adr[ADDR_W-1:0]; // upper bits alias

	// new strobe, or a following cycle with stb held through the ack
	assign access = wb_in.cyc && wb_in.stb && !ack_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	always_ff @(posedge clk) begin
		if (access) begin
			rd_q <= mem[idx];
			if (wb_in.we) begin
				for (int i = 0; i < LANES; i++) begin
					if (wb_in.sel[i])
						mem[idx][8*i +: 8] <= wb_in.dat[8*i +: 8];
				end
			end
		end
	end

	assign wb_out.ack = ack_q;
	assign wb_out.dat = rd_q;

endmodule

`default_nettype wire

/* core_mem_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_mem_top (
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    insn_start,
	input  core_bus_pkg::ptr        insn_addr,
	output logic                    insn_ready,
	output core_bus_pkg::word       insn_data_rd,

	input  logic                    data_start,
	input  core_bus_pkg::core_req_t data_req,
	output logic                    data_ready,
	output logic                    data_ex_fail,
	output core_bus_pkg::word       data_data_rd
);

	logic bus_start;
	logic bus_ready;
	logic bus_ex_fail;
	core_bus_pkg::core_req_t bus_req;
	core_bus_pkg::word bus_data_rd;
	core_bus_pkg::wb_m2s_t wb_m2s;
	core_bus_pkg::wb_s2m_t wb_s2m;

	core_mmu_arbiter core_mmu_arbiter_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.insn_start   (insn_start),
		.insn_addr    (insn_addr),
		.data_start   (data_start),
		.data_req     (data_req),
		.bus_ready    (bus_ready),
		.bus_ex_fail  (bus_ex_fail),
		.bus_data_rd  (bus_data_rd),
		.bus_start    (bus_start),
		.bus_req      (bus_req),
		.insn_ready   (insn_ready),
		.data_ready   (data_ready),
		.data_ex_fail (data_ex_fail),
		.insn_data_rd (insn_data_rd),
		.data_data_rd (data_data_rd)
	);

	core_wb_bridge core_wb_bridge_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus_start   (bus_start),
		.bus_req     (bus_req),
		.bus_ready   (bus_ready),
		.bus_ex_fail (bus_ex_fail),
		.bus_data_rd (bus_data_rd),
		.wb_out      (wb_m2s),
		.wb_in       (wb_s2m)
	);

	core_wb_ram core_wb_ram_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_in  (wb_m2s),
		.wb_out (wb_s2m)
	);

endmodule

`default_nettype wire

/* core_mem_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module core_mem_assert (
	input logic                  clk,
	input logic                  rst_n,
	input core_bus_pkg::wb_m2s_t wb_m2s,
	input core_bus_pkg::wb_s2m_t wb_s2m,
	input logic                  insn_ready,
	input logic                  data_ready,
	input logic                  data_ex_fail
);

	// master fields frozen while waiting for ack
	wb_hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_m2s.stb && !wb_s2m.ack) |=> (wb_m2s.cyc && wb_m2s.stb
			&& $stable(wb_m2s.we) && $stable(wb_m2s.adr)
			&& $stable(wb_m2s.dat) && $stable(wb_m2s.sel)))
		else $error("wishbone strobe dropped or request changed before ack");

	wb_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wb_s2m.ack |-> (wb_m2s.cyc && wb_m2s.stb))
		else $error("ack outside of a strobed cycle");

	one_ready_at_a_time: assert property (@(posedge clk) disable iff (!rst_n)
		!(insn_ready && data_ready))
		else $error("insn_ready and data_ready high together");

	ex_fail_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
		data_ex_fail |-> data_ready)
		else $error("data_ex_fail without data_ready");

endmodule

bind core_mem_top core_mem_assert core_mem_assert_inst (
	.clk          (clk),
	.rst_n        (rst_n),
	.wb_m2s       (wb_m2s),
	.wb_s2m       (wb_s2m),
	.insn_ready   (insn_ready),
	.data_ready   (data_ready),
	.data_ex_fail (data_ex_fail)
);

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* core_mem_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_bus_config.svh"

module core_mem_tb;

	localparam int IDX_W = $clog2(`CORE_RAM_WORDS);
	localparam int WINDOW = 32; // words under test, low 5 address bits
	localparam int WATCHDOG_CYCLES = `CORE_TEST_OPS * 2 * 12;

	logic clk;
	logic rst_n;
	logic insn_start;
	core_bus_pkg::ptr insn_addr;
	logic insn_ready;
	core_bus_pkg::word insn_data_rd;
	logic data_start;
	core_bus_pkg::core_req_t data_req;
	logic data_ready;
	logic data_ex_fail;
	core_bus_pkg::word data_data_rd;

	core_bus_pkg::word model [`CORE_RAM_WORDS];
	logic res_valid = 1'b0; // reservation as the bridge should see it
	core_bus_pkg::ptr res_addr = '0;
	core_bus_pkg::ptr lock_addr = '0;
	logic [31:0] rng_state = 32'd3395;
	logic fill_done = 1'b0;
	logic insn_finished = 1'b0;
	logic data_finished = 1'b0;
	int insn_issued = 0;
	int data_issued = 0;
	int insn_ready_seen = 0;
	int data_ready_seen = 0;

	tb_clock_gen tb_clock_gen_inst (
		.clk   (clk),
		.rst_n (rst_n)
	);

	core_mem_top core_mem_top_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.insn_start   (insn_start),
		.insn_addr    (insn_addr),
		.insn_ready   (insn_ready),
		.insn_data_rd (insn_data_rd),
		.data_start   (data_start),
		.data_req     (data_req),
		.data_ready   (data_ready),
		.data_ex_fail (data_ex_fail),
		.data_data_rd (data_data_rd)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// low bits pick a word in the window, now and then alias it higher up
	function automatic core_bus_pkg::ptr pick_addr(input logic [31:0] r);
		core_bus_pkg::ptr a;
		a = '0;
		a[4:0] = r[4:0];
		if (r[10:8] == 3'd0)
			a[29:20] = r[31:22];
		return a;
	endfunction

	function automatic core_bus_pkg::word merge_lanes(input core_bus_pkg::word old_w,
		input core_bus_pkg::word new_w, input core_bus_pkg::be_t be);
		core_bus_pkg::word w;
		w = old_w;
		for (int i = 0; i < 4; i++) begin
			if (be[i])
				w[8*i +: 8] = new_w[8*i +: 8];
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error: %s expected %08h actual %08h", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic insn_fetch(input core_bus_pkg::ptr addr, output core_bus_pkg::word rd);
		int cycles;
		@(posedge clk);
		insn_addr <= addr;
		insn_start <= 1'b1;
		insn_issued++;
		@(posedge clk);
		insn_start <= 1'b0;
		cycles = 1;
		@(negedge clk);
		while (insn_ready !== 1'b1) begin
			@(negedge clk);
			cycles++;
		end
		rd = insn_data_rd;
		check_value("insn latency within 6 cycles", 32'd1, 32'(cycles <= 6));
	endtask

	task automatic data_access(input core_bus_pkg::core_req_t req,
		output core_bus_pkg::word rd, output logic ex_fail);
		int cycles;
		@(posedge clk);
		data_req <= req;
		data_start <= 1'b1;
		data_issued++;
		@(posedge clk);
		data_start <= 1'b0;
		cycles = 1;
		@(negedge clk);
		while (data_ready !== 1'b1) begin
			@(negedge clk);
			cycles++;
		end
		rd = data_data_rd;
		ex_fail = data_ex_fail;
		check_value("data latency within 6 cycles", 32'd1, 32'(cycles <= 6));
	endtask

	always @(negedge clk) begin
		if (insn_ready === 1'b1)
			insn_ready_seen++;
		if (data_ready === 1'b1)
			data_ready_seen++;
	end

	initial begin : data_requester
		core_bus_pkg::core_req_t req;
		core_bus_pkg::word rd;
		logic ex_fail;
		logic exp_fail;
		logic [31:0] r;
		logic [IDX_W-1:0] idx;
		wait (rst_n === 1'b1);
		// every word in the window starts known
		for (int i = 0; i < WINDOW; i++) begin
			req = '0;
			req.addr = 30'(i);
			req.write = 1'b1;
			req.data_wr = next_random();
			req.be = '1;
			data_access(req, rd, ex_fail);
			model[req.addr[IDX_W-1:0]] = req.data_wr;
		end
		fill_done = 1'b1;

		for (int n = 0; n < `CORE_TEST_OPS; n++) begin
			r = next_random();
			repeat (r[1:0]) @(posedge clk);
			req = '0;
			req.addr = pick_addr(next_random());
			req.data_wr = next_random();
			req.be = r[7:4];
			req.write = r[10:8] >= 3'd3 && r[10:8] != 3'd5; // 3,4 plain, 6,7 locked
			req.ex_lock = r[10:8] >= 3'd5;
			if (req.write && req.ex_lock && r[12:11] != 2'd0)
				req.addr = lock_addr; // mostly pair with the last load-locked
			idx = req.addr[IDX_W-1:0];
			exp_fail = req.write && req.ex_lock && !(res_valid && res_addr == req.addr);

			data_access(req, rd, ex_fail);
			check_value("data_ex_fail", 32'(exp_fail), 32'(ex_fail));
			if (!req.write) begin
				check_value("data read", model[idx], rd);
				if (req.ex_lock) begin
					res_valid = 1'b1;
					res_addr = req.addr;
					lock_addr = req.addr;
				end
			end else begin
				if (!exp_fail)
					model[idx] = merge_lanes(model[idx], req.data_wr, req.be);
				res_valid = 1'b0;
			end

			// read back right after a store-conditional
			if (req.write && req.ex_lock) begin
				req.write = 1'b0;
				req.ex_lock = 1'b0;
				data_access(req, rd, ex_fail);
				check_value("store-conditional readback", model[idx], rd);
			end
		end
		data_finished = 1'b1;
	end

	initial begin : insn_requester
		core_bus_pkg::ptr a;
		core_bus_pkg::word rd;
		logic [31:0] r;
		wait (fill_done === 1'b1);
		for (int n = 0; n < `CORE_TEST_OPS; n++) begin
			r = next_random();
			repeat (r[1:0]) @(posedge clk);
			a = pick_addr(next_random());
			insn_fetch(a, rd);
			check_value("insn fetch", model[a[IDX_W-1:0]], rd);
		end
		insn_finished = 1'b1;
	end

	initial begin : run_control
		insn_start = 1'b0;
		insn_addr = '0;
		data_start = 1'b0;
		data_req = '0;
		wait (insn_finished && data_finished);
		repeat (8) @(posedge clk); // room for any stray ready
		check_value("insn_ready count", 32'(insn_issued), 32'(insn_ready_seen));
		check_value("data_ready count", 32'(data_issued), 32'(data_ready_seen));
		$display("Simulation PASSED");
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired while requests were still waiting for ready");
		$display("Simulation FAILED");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
core_bus_pkg.sv
core_mmu_arbiter.sv
core_wb_bridge.sv
core_wb_ram.sv
core_mem_top.sv
core_mem_assert.sv
tb_clock_gen.sv
core_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and pass only if the testbench reports a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module core_mem_tb \
	&& ./obj_dir/Vcore_mem_tb 2>&1 | tee /dev/stderr | grep -q "Simulation PASSED" \
	&& echo "run_sim: test passed" && exit 0 \
	|| { echo "run_sim: test failed"; exit 1; }
